//--- Bender.yml
package:
  name: cpucore

dependencies: {}

sources:
  - rtl/cpuPkg.sv
  - rtl/alu.sv
  - rtl/programCounter.sv
  - rtl/cpuRegisters.sv
  - rtl/controlFsm.sv
  - rtl/cpuTop.sv
  - target: test
    files:
      - tests/cpuSva.sv
      - tests/cpuTb.sv

//--- build.f
rtl/cpuPkg.sv
rtl/alu.sv
rtl/programCounter.sv
rtl/cpuRegisters.sv
rtl/controlFsm.sv
rtl/cpuTop.sv
tests/cpuSva.sv
tests/cpuTb.sv

//--- rtl/alu.sv
/* combinational 8-bit ALU: pass, binary add with carry, logic ops and
   increment, with n/z from the result and c/v from the adder */
`timescale 1ns/10ps

module alu (
  input  cpuPkg::aluOpT op,
  input  cpuPkg::byteT  a,
  input  cpuPkg::byteT  b,
  input  logic          carryIn,
  output cpuPkg::byteT  result,
  output cpuPkg::flagsT flagsOut
);

  import cpuPkg::*;

  logic [8:0] sum;
  logic       overflow;

  assign sum = {1'b0, a} + {1'b0, b} + {8'd0, carryIn};

  // signed overflow when both inputs agree in sign and the sum does not
  assign overflow = (a[7] == b[7]) && (sum[7] != a[7]);

  always_comb begin
    case (op)
      aluAdd: begin
        result = sum[7:0];
      end
      aluAnd: begin
        result = a & b;
      end
      aluOr: begin
        result = a | b;
      end
      aluEor: begin
        result = a ^ b;
      end
      aluInc: begin
        result = a + 8'd1;
      end
      default: begin
        result = a;
      end
    endcase
  end

  always_comb begin
    flagsOut.n = result[7];
    flagsOut.z = (result == 8'd0);
    // carry and overflow only come from the adder
    flagsOut.c = (op == aluAdd) ? sum[8] : 1'b0;
    flagsOut.v = (op == aluAdd) ? overflow : 1'b0;
  end

endmodule

//--- rtl/controlFsm.sv
/* timing-state controller: latches the opcode on the sync cycle and drives
   the datapath controls, bus request and next state for each cycle */
`timescale 1ns/10ps

module controlFsm #(
  parameter cpuPkg::addrT resetVector = 16'hFFFC
) (
  input  logic          phi0,
  input  logic          rst,
  input  logic          memReady,
  input  cpuPkg::byteT  memRdata,
  input  cpuPkg::flagsT flags,
  output cpuPkg::ctrlT  ctrl,
  output logic          memValid,
  output logic          memWrite,
  output logic          sync
);

  import cpuPkg::*;

  cpuStateT state;
  cpuStateT nextState;
  opcodeT   opcode;
  logic     advance;
  logic     branchTaken;

  // sExec has no transfer and moves on right away
  assign advance = memReady || (state == sExec);

  assign memValid = (state != sExec);
  assign memWrite = (state == sStore);
  assign sync = (state == sFetch);

  always_comb begin
    case (opcode)
      opBeq: begin
        branchTaken = flags.z;
      end
      opBne: begin
        branchTaken = !flags.z;
      end
      opBcs: begin
        branchTaken = flags.c;
      end
      default: begin
        branchTaken = 1'b0;
      end
    endcase
  end

  always_comb begin
    ctrl = '0;
    ctrl.addrSelect = addrSelPc;
    nextState = state;
    case (state)
      sReset0: begin
        // vector pair assumed on an even address
        ctrl.addrSelect = {addrSelVector[1], resetVector[0]};
        ctrl.pcLoadVector = 1'b1;
        nextState = sReset1;
      end
      sReset1: begin
        ctrl.addrSelect = {addrSelVector[1], ~resetVector[0]};
        ctrl.pcLoadVector = 1'b1;
        nextState = sFetch;
      end
      sFetch: begin
        ctrl.pcIncrement = 1'b1;
        nextState = sOperand;
      end
      sOperand: begin
        nextState = sFetch;
        case (opcode)
          opLdaImm, opLdxImm: begin
            ctrl.aluOp = aluPass;
            ctrl.aluSrcX = 1'b1;
            ctrl.loadA = (opcode == opLdaImm);
            ctrl.loadX = (opcode == opLdxImm);
            ctrl.loadFlags = 1'b1;
            ctrl.pcIncrement = 1'b1;
          end
          opAdcImm, opAndImm, opOraImm, opEorImm: begin
            if (opcode == opAdcImm) begin
              ctrl.aluOp = aluAdd;
            end else if (opcode == opAndImm) begin
              ctrl.aluOp = aluAnd;
            end else if (opcode == opOraImm) begin
              ctrl.aluOp = aluOr;
            end else begin
              ctrl.aluOp = aluEor;
            end
            ctrl.loadA = 1'b1;
            ctrl.loadFlags = 1'b1;
            ctrl.pcIncrement = 1'b1;
          end
          opStaAbs, opJmpAbs: begin
            ctrl.latchOperandLo = 1'b1;
            ctrl.pcIncrement = 1'b1;
            nextState = sAddrHi;
          end
          opInx: begin
            ctrl.aluOp = aluInc;
            ctrl.aluSrcX = 1'b1;
            ctrl.loadX = 1'b1;
            ctrl.loadFlags = 1'b1;
          end
          opTax: begin
            ctrl.aluOp = aluPass;
            ctrl.loadX = 1'b1;
            ctrl.loadFlags = 1'b1;
          end
          opSec: begin
            ctrl.setCarry = 1'b1;
          end
          opClc: begin
            ctrl.clearCarry = 1'b1;
          end
          opBeq, opBne, opBcs: begin
            ctrl.latchOperandLo = 1'b1;
            ctrl.pcIncrement = 1'b1;
            nextState = branchTaken ? sExec : sFetch;
          end
          default: begin
            // implied dummy read, pc stays put
            nextState = sFetch;
          end
        endcase
      end
      sAddrHi: begin
        if (opcode == opJmpAbs) begin
          ctrl.pcLoadJump = 1'b1;
          nextState = sFetch;
        end else begin
          ctrl.latchOperandHi = 1'b1;
          ctrl.pcIncrement = 1'b1;
          nextState = sStore;
        end
      end
      sStore: begin
        ctrl.addrSelect = addrSelOperand;
        ctrl.storeA = 1'b1;
        nextState = sFetch;
      end
      sExec: begin
        ctrl.pcBranch = 1'b1;
        nextState = sFetch;
      end
      default: begin
        nextState = sReset0;
      end
    endcase
  end

  always_ff @(posedge phi0) begin
    if (rst) begin
      state <= sReset0;
      opcode <= opNop;
    end else begin
      if (advance) begin
        state <= nextState;
      end
      if (state == sFetch && memReady) begin
        opcode <= opcodeT'(memRdata);
      end
    end
  end

endmodule

//--- rtl/cpuPkg.sv
/* shared types for the 6502-style core: widths, opcodes, controller states,
   datapath control word and memory request payload */
package cpuPkg;

  typedef logic [7:0] byteT;
  typedef logic [15:0] addrT;

  // supported opcodes, everything else runs as a NOP
  typedef enum byteT {
    opLdaImm = 8'hA9,
    opLdxImm = 8'hA2,
    opAdcImm = 8'h69,
    opAndImm = 8'h29,
    opOraImm = 8'h09,
    opEorImm = 8'h49,
    opStaAbs = 8'h8D,
    opInx    = 8'hE8,
    opTax    = 8'hAA,
    opSec    = 8'h38,
    opClc    = 8'h18,
    opNop    = 8'hEA,
    opJmpAbs = 8'h4C,
    opBeq    = 8'hF0,
    opBne    = 8'hD0,
    opBcs    = 8'hB0
  } opcodeT;

  typedef enum logic [2:0] {
    sReset0,
    sReset1,
    sFetch,
    sOperand,
    sAddrHi,
    sExec,
    sStore
  } cpuStateT;

  typedef enum logic [2:0] {
    aluPass,
    aluAdd,
    aluAnd,
    aluOr,
    aluEor,
    aluInc
  } aluOpT;

  // address mux select, bit 0 of a vector select is the vector address lsb
  typedef logic [1:0] addrSelT;
  localparam addrSelT addrSelPc = 2'b00;
  localparam addrSelT addrSelOperand = 2'b01;
  localparam addrSelT addrSelVector = 2'b10;

  typedef struct packed {
    logic n;
    logic v;
    logic z;
    logic c;
  } flagsT;

  typedef struct packed {
    addrT addr;
    byteT wdata;
    logic write;
  } memReqT;

  typedef struct packed {
    aluOpT   aluOp;
    logic    aluSrcX;
    logic    loadA;
    logic    loadX;
    logic    loadFlags;
    logic    setCarry;
    logic    clearCarry;
    logic    latchOperandLo;
    logic    latchOperandHi;
    logic    pcIncrement;
    logic    pcLoadVector;
    logic    pcLoadJump;
    logic    pcBranch;
    addrSelT addrSelect;
    logic    storeA;
  } ctrlT;

endpackage

//--- rtl/cpuRegisters.sv
/* register datapath: A, X, the status flags and the operand address latch,
   plus the operand selection feeding the ALU and the store data bus */
`timescale 1ns/10ps

module cpuRegisters (
  input  logic          phi0,
  input  logic          rst,
  input  cpuPkg::ctrlT  ctrl,
  input  logic          fire,
  input  cpuPkg::byteT  memRdata,
  input  cpuPkg::byteT  aluResult,
  input  cpuPkg::flagsT aluFlags,
  output cpuPkg::byteT  aluA,
  output cpuPkg::addrT  operandAddr,
  output cpuPkg::byteT  storeData,
  output cpuPkg::flagsT flags
);

  import cpuPkg::*;

  byteT aReg;
  byteT xReg;

  // first ALU operand; loads run the memory byte through pass
  always_comb begin
    if (ctrl.aluSrcX && ctrl.aluOp == aluPass) begin
      aluA = memRdata;
    end else if (ctrl.aluSrcX) begin
      aluA = xReg;
    end else begin
      aluA = aReg;
    end
  end

  assign storeData = ctrl.storeA ? aReg : xReg;

  always_ff @(posedge phi0) begin
    if (rst) begin
      aReg <= '0;
      xReg <= '0;
      flags <= '0;
    end else if (fire) begin
      if (ctrl.loadA) begin
        aReg <= aluResult;
      end
      if (ctrl.loadX) begin
        xReg <= aluResult;
      end
      if (ctrl.loadFlags) begin
        flags.n <= aluFlags.n;
        flags.z <= aluFlags.z;
        // only ADC touches c and v
        if (ctrl.aluOp == aluAdd) begin
          flags.c <= aluFlags.c;
          flags.v <= aluFlags.v;
        end
      end
      if (ctrl.setCarry) begin
        flags.c <= 1'b1;
      end
      if (ctrl.clearCarry) begin
        flags.c <= 1'b0;
      end
    end
  end

  // operand latch holds the absolute address or the branch offset
  always_ff @(posedge phi0) begin
    if (fire && ctrl.latchOperandLo) begin
      operandAddr[7:0] <= memRdata;
    end
    if (fire && ctrl.latchOperandHi) begin
      operandAddr[15:8] <= memRdata;
    end
  end

endmodule

//--- rtl/cpuTop.sv
/* core top level: joins the controller, program counter, registers and ALU
   and presents a single valid/ready memory port */
`timescale 1ns/10ps

module cpuTop #(
  parameter cpuPkg::addrT resetVector = 16'hFFFC
) (
  input  logic           phi0,
  input  logic           rst,
  output logic           memValid,
  output cpuPkg::memReqT memReq,
  input  logic           memReady,
  input  cpuPkg::byteT   memRdata,
  output logic           sync
);

  import cpuPkg::*;

  ctrlT  ctrl;
  flagsT flags;
  flagsT aluFlags;
  addrT  pc;
  addrT  operandAddr;
  addrT  reqAddr;
  byteT  storeData;
  byteT  aluA;
  byteT  aluResult;
  logic  memWrite;
  logic  fire;

  // one transfer per valid/ready handshake
  assign fire = memValid && memReady;

  always_comb begin
    case (ctrl.addrSelect)
      addrSelPc: begin
        reqAddr = pc;
      end
      addrSelOperand: begin
        reqAddr = operandAddr;
      end
      default: begin
        reqAddr = {resetVector[15:1], ctrl.addrSelect[0]};
      end
    endcase
  end

  assign memReq = '{addr: reqAddr, wdata: storeData, write: memWrite};

  controlFsm #(.resetVector(resetVector)) u_controlFsm (
    .phi0(phi0),
    .rst(rst),
    .memReady(memReady),
    .memRdata(memRdata),
    .flags(flags),
    .ctrl(ctrl),
    .memValid(memValid),
    .memWrite(memWrite),
    .sync(sync)
  );

  programCounter #(.resetVector(resetVector)) u_programCounter (
    .phi0(phi0),
    .rst(rst),
    .ctrl(ctrl),
    .fire(fire),
    .memRdata(memRdata),
    .operandAddr(operandAddr),
    .pc(pc)
  );

  cpuRegisters u_cpuRegisters (
    .phi0(phi0),
    .rst(rst),
    .ctrl(ctrl),
    .fire(fire),
    .memRdata(memRdata),
    .aluResult(aluResult),
    .aluFlags(aluFlags),
    .aluA(aluA),
    .operandAddr(operandAddr),
    .storeData(storeData),
    .flags(flags)
  );

  alu u_alu (
    .op(ctrl.aluOp),
    .a(aluA),
    .b(memRdata),
    .carryIn(flags.c),
    .result(aluResult),
    .flagsOut(aluFlags)
  );

endmodule

//--- rtl/programCounter.sv
/* program counter: steps on each accepted fetch, assembles the reset vector
   byte by byte, loads jump targets and applies taken branch offsets */
`timescale 1ns/10ps

module programCounter #(
  parameter cpuPkg::addrT resetVector = 16'hFFFC
) (
  input  logic          phi0,
  input  logic          rst,
  input  cpuPkg::ctrlT  ctrl,
  input  logic          fire,
  input  cpuPkg::byteT  memRdata,
  input  cpuPkg::addrT  operandAddr,
  output cpuPkg::addrT  pc
);

  import cpuPkg::*;

  addrT branchOffset;

  // offset byte sits in the low half of the operand latch
  assign branchOffset = {{8{operandAddr[7]}}, operandAddr[7:0]};

  always_ff @(posedge phi0) begin
    if (rst) begin
      pc <= resetVector;
    end else if (ctrl.pcBranch) begin
      // internal cycle, no transfer to wait for
      pc <= pc + branchOffset;
    end else if (fire) begin
      if (ctrl.pcLoadVector) begin
        // low byte arrives first and gets shifted down by the high byte
        pc <= {memRdata, pc[15:8]};
      end else if (ctrl.pcLoadJump) begin
        pc <= {memRdata, operandAddr[7:0]};
      end else if (ctrl.pcIncrement) begin
        pc <= pc + 16'd1;
      end
    end
  end

endmodule

//--- tests/cpuSva.sv
/* concurrent checks on the memory handshake and on the state right after
   reset, bound into cpuTop by the testbench */
`timescale 1ns/10ps

module cpuSva #(
  parameter cpuPkg::addrT resetVector = 16'hFFFC
) (
  input logic           phi0,
  input logic           rst,
  input logic           memValid,
  input cpuPkg::memReqT memReq,
  input logic           memReady,
  input logic           sync,
  input cpuPkg::flagsT  flags,
  input cpuPkg::byteT   aReg,
  input cpuPkg::byteT   xReg
);

  import cpuPkg::*;

  localparam addrT vectorLo = {resetVector[15:1], 1'b0};

  int failCount = 0;

  // a stalled request holds until the memory takes it
  reqStable: assert property (@(posedge phi0) disable iff (rst)
    memValid && !memReady |=> memValid && $stable(memReq))
  else begin
    $error("memory request changed while memReady was low");
    failCount++;
  end

  // first cycle out of reset reads the low vector byte
  resetBus: assert property (@(posedge phi0)
    $past(rst) && !rst |-> memValid && !sync && !memReq.write && memReq.addr == vectorLo)
  else begin
    $error("bus request after reset is not the vector low read");
    failCount++;
  end

  resetRegs: assert property (@(posedge phi0)
    $past(rst) && !rst |-> aReg == 8'h00 && xReg == 8'h00 && flags == '0)
  else begin
    $error("A, X or flags not cleared by reset");
    failCount++;
  end

endmodule

//--- tests/cpuTb.sv
/* testbench for cpuTop: runs short programs from a behavioral memory, with
   and without random memory stalls, and checks bus writes and fetch addresses */
`timescale 1ns/10ps

module cpuTb;

  import cpuPkg::*;

  localparam addrT resetVector = 16'hFFFC;
  localparam int waitLimit = 400;

  logic   phi0 = 1'b0;
  logic   rst;
  logic   memValid;
  memReqT memReq;
  logic   memReady;
  byteT   memRdata;
  logic   sync;

  byteT  mem [65536];
  addrT  firstAddr [2];
  int    xferIndex;
  int    resetLeft;
  logic  stallOn;
  logic  wrSeen;
  addrT  wrAddr;
  byteT  wrData;
  logic  fetchSeen;
  addrT  fetchAddr;
  string testName;
  int    testErrors;
  int    testsRun;
  int    testsFailed;

  cpuTop #(.resetVector(resetVector)) u_cpuTop (
    .phi0(phi0),
    .rst(rst),
    .memValid(memValid),
    .memReq(memReq),
    .memReady(memReady),
    .memRdata(memRdata),
    .sync(sync)
  );

  bind cpuTop cpuSva #(.resetVector(resetVector)) u_cpuSva (
    .phi0(phi0),
    .rst(rst),
    .memValid(memValid),
    .memReq(memReq),
    .memReady(memReady),
    .sync(sync),
    .flags(flags),
    .aReg(u_cpuRegisters.aReg),
    .xReg(u_cpuRegisters.xReg)
  );

  always #4 phi0 = ~phi0;

  task automatic abortRun(string what);
    $display("ERROR: %s", what);
    $display("Result: FAILED");
    $finish;
  endtask

  function automatic void checkValue(string name, logic [15:0] got, logic [15:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
      testErrors++;
    end
  endfunction

  // next instruction address plus the signed offset
  function automatic addrT branchDest(addrT at, byteT offset);
    return addrT'(int'(at) + 2 + int'($signed(offset)));
  endfunction

  // one clock; memory inputs change just after the edge
  task automatic tick();
    @(posedge phi0);
    #1;
    rst = (resetLeft > 0);
    if (resetLeft > 0) begin
      resetLeft--;
    end
    wrSeen = 1'b0;
    fetchSeen = 1'b0;
    memReady = stallOn ? ($urandom % 3 != 0) : 1'b1;
    memRdata = mem[memReq.addr];
    if (!rst && memValid && memReady) begin
      if (xferIndex < 2) begin
        firstAddr[xferIndex] = memReq.addr;
      end
      xferIndex++;
      if (memReq.write) begin
        mem[memReq.addr] = memReq.wdata;
        wrSeen = 1'b1;
        wrAddr = memReq.addr;
        wrData = memReq.wdata;
      end else if (sync) begin
        fetchSeen = 1'b1;
        fetchAddr = memReq.addr;
      end
    end
  endtask

  task automatic nextWrite(addrT expAddr, byteT expData);
    int n;
    n = 0;
    do begin
      tick();
      n++;
    end while (!wrSeen && n < waitLimit);
    if (!wrSeen) begin
      abortRun("no memory write arrived in time");
    end else begin
      checkValue("memReq.addr", wrAddr, expAddr);
      checkValue("memReq.wdata", wrData, expData);
    end
  endtask

  // waits for a fetch at expAddr when skip is set, otherwise checks the next fetch
  task automatic fetchAt(addrT expAddr, logic skip);
    int n;
    n = 0;
    do begin
      tick();
      n++;
    end while (!(fetchSeen && (!skip || fetchAddr == expAddr)) && n < waitLimit);
    if (!fetchSeen || (skip && fetchAddr != expAddr)) begin
      abortRun($sformatf("no opcode fetch at 0x%h arrived in time", expAddr));
    end else if (!skip) begin
      checkValue("memReq.addr (fetch)", fetchAddr, expAddr);
    end
  endtask

  task automatic loadProgram(addrT entry, byteT code[$]);
    for (int i = 0; i < 65536; i++) begin
      mem[i] = byteT'(i ^ (i >> 8));
    end
    foreach (code[i]) begin
      mem[addrT'(entry + i)] = code[i];
    end
    mem[resetVector] = entry[7:0];
    mem[resetVector + 16'd1] = entry[15:8];
  endtask

  task automatic startRun(string name, addrT entry, logic stall);
    testName = name;
    testErrors = 0;
    stallOn = stall;
    xferIndex = 0;
    rst = 1'b1;
    resetLeft = 2;
    repeat (3) tick();
    // two vector reads, then the first fetch at the vector contents
    fetchAt(entry, 1'b0);
    checkValue("memReq.addr (vector low)", firstAddr[0], resetVector);
    checkValue("memReq.addr (vector high)", firstAddr[1], resetVector + 16'd1);
  endtask

  task automatic finishTest();
    testsRun++;
    if (testErrors != 0) begin
      testsFailed++;
    end
    $display("test %s, stalls %0d: %0d errors", testName, stallOn, testErrors);
  endtask

  task automatic loadStoreTest(logic stall);
    byteT code[$];
    byteT x;
    // LDA #$5A, STA $0300, TAX, INX, LDA #$C3, STA $1234, JMP $020C
    code = {8'hA9, 8'h5A, 8'h8D, 8'h00, 8'h03, 8'hAA, 8'hE8,
            8'hA9, 8'hC3, 8'h8D, 8'h34, 8'h12, 8'h4C, 8'h0C, 8'h02};
    loadProgram(16'h0200, code);
    startRun("loadStore", 16'h0200, stall);
    nextWrite(16'h0300, 8'h5A);
    x = 8'h5A + 8'h01;
    fetchAt(16'h0207, 1'b1);
    checkValue("xReg", u_cpuTop.u_cpuRegisters.xReg, x);
    nextWrite(16'h1234, 8'hC3);
    fetchAt(16'h020C, 1'b0);
    // jump onto itself
    fetchAt(16'h020C, 1'b0);
    finishTest();
  endtask

  task automatic arithTest(logic stall);
    byteT code[$];
    byteT a;
    // LDA #$C8, SEC, ADC #$45, STA, CLC, ADC #$F0, STA, AND #$3C, STA,
    // ORA #$81, STA, EOR #$FF, STA, JMP $041D
    code = {8'hA9, 8'hC8, 8'h38, 8'h69, 8'h45, 8'h8D, 8'h10, 8'h03,
            8'h18, 8'h69, 8'hF0, 8'h8D, 8'h11, 8'h03,
            8'h29, 8'h3C, 8'h8D, 8'h12, 8'h03,
            8'h09, 8'h81, 8'h8D, 8'h13, 8'h03,
            8'h49, 8'hFF, 8'h8D, 8'h14, 8'h03,
            8'h4C, 8'h1D, 8'h04};
    loadProgram(16'h0400, code);
    startRun("arith", 16'h0400, stall);
    a = 8'hC8 + 8'h45 + 8'h01;
    nextWrite(16'h0310, a);
    a = a + 8'hF0;
    nextWrite(16'h0311, a);
    a = a & 8'h3C;
    nextWrite(16'h0312, a);
    a = a | 8'h81;
    nextWrite(16'h0313, a);
    a = a ^ 8'hFF;
    nextWrite(16'h0314, a);
    finishTest();
  endtask

  task automatic branchTest(logic stall);
    byteT code[$];
    logic [8:0] sum;
    byteT x;
    // LDA #$F0, CLC, ADC #$20, BCS +4, 4 NOPs, ADC #$01, BCS -6, LDX #$FF,
    // INX, BEQ +2, 2 NOPs, BNE -16, INX, BEQ +16, BNE -12
    code = {8'hA9, 8'hF0, 8'h18, 8'h69, 8'h20, 8'hB0, 8'h04,
            8'hEA, 8'hEA, 8'hEA, 8'hEA, 8'h69, 8'h01, 8'hB0, 8'hFA,
            8'hA2, 8'hFF, 8'hE8, 8'hF0, 8'h02, 8'hEA, 8'hEA,
            8'hD0, 8'hF0, 8'hE8, 8'hF0, 8'h10, 8'hD0, 8'hF4};
    loadProgram(16'h0600, code);
    startRun("branch", 16'h0600, stall);
    sum = 9'h0F0 + 9'h020;
    fetchAt(16'h0605, 1'b1);
    fetchAt(sum[8] ? branchDest(16'h0605, 8'h04) : 16'h0607, 1'b0);
    sum = {1'b0, sum[7:0]} + 9'h001 + {8'h00, sum[8]};
    fetchAt(16'h060D, 1'b1);
    fetchAt(sum[8] ? branchDest(16'h060D, 8'hFA) : 16'h060F, 1'b0);
    x = 8'hFF + 8'h01;
    fetchAt(16'h0612, 1'b1);
    fetchAt(x == 8'h00 ? branchDest(16'h0612, 8'h02) : 16'h0614, 1'b0);
    fetchAt(x != 8'h00 ? branchDest(16'h0616, 8'hF0) : 16'h0618, 1'b0);
    x = x + 8'h01;
    fetchAt(16'h0619, 1'b0);
    fetchAt(x == 8'h00 ? branchDest(16'h0619, 8'h10) : 16'h061B, 1'b0);
    fetchAt(x != 8'h00 ? branchDest(16'h061B, 8'hF4) : 16'h061D, 1'b0);
    finishTest();
  endtask

  initial begin
    rst = 1'b1;
    memReady = 1'b0;
    memRdata = '0;
    resetLeft = 0;
    stallOn = 1'b0;
    testsRun = 0;
    testsFailed = 0;
    void'($urandom(32'h4c91_3574));
    loadStoreTest(1'b0);
    arithTest(1'b0);
    branchTest(1'b0);
    loadStoreTest(1'b1);
    arithTest(1'b1);
    branchTest(1'b1);
    $display("tests run %0d, tests failed %0d, assertion failures %0d",
             testsRun, testsFailed, u_cpuTop.u_cpuSva.failCount);
    if (testsFailed == 0 && u_cpuTop.u_cpuSva.failCount == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
